/* files.f */
+incdir+src
src/ics32_periph_pkg.sv
src/periph_bus_if.sv
src/address_decoder.sv
src/bus_arbiter.sv
src/dsp_multiplier.sv
src/gamepad_reader.sv
src/flash_ctrl.sv
src/ics32_periph.sv
sim/ics32_periph_checker.sv
sim/ics32_periph_tb.sv

/* sim/ics32_periph_checker.sv */
// Bus protocol checker
// Concurrent assertions on the ready pulse and the state right after reset

module ics32_periph_checker (
    input logic       vdp_clk,
    input logic       vdp_reset,
    input logic       bus_valid,
    input logic       bus_ready,
    input logic       led_r,
    input logic       led_b,
    input logic       flash_clk,
    input logic       flash_csn,
    input logic [3:0] flash_in,
    input logic [3:0] flash_in_en
);

    // Number of failed assertions
    int failures = 0;

    // Ready is a single-cycle pulse
    ready_pulse: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        bus_ready |=> !bus_ready)
        else begin
            $error("bus_ready stayed high for two cycles");
            failures++;
        end

    ready_with_valid: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        bus_ready |-> bus_valid)
        else begin
            $error("bus_ready raised while bus_valid was low");
            failures++;
        end

    // First cycle out of reset
    reset_state: assert property (@(posedge vdp_clk)
        $fell(vdp_reset) |-> led_r && !led_b && !bus_ready && !flash_clk && flash_csn
                             && flash_in == 4'h0 && flash_in_en == 4'h0)
        else begin
            $error("LEDs or flash pins not at their reset values after reset");
            failures++;
        end

endmodule

bind ics32_periph ics32_periph_checker protocol_check (.*);

/* sim/ics32_periph_tb.sv */
// Testbench for the peripheral bus slave
// Issues valid/ready requests to every region and checks read data, LEDs
// and flash pins against a register model

`include "ics32_periph_cfg.svh"

module ics32_periph_tb;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 5;
    localparam int N_STATUS    = 8;
    localparam int N_MULT      = 20;
    localparam int N_PAD       = 3;
    localparam int N_FLASH     = 10;
    // Requests issued over the whole run
    localparam int NUM_TESTS = 2 * N_STATUS + 24 + 3 * N_MULT
                             + N_PAD * (2 + 3 * `ICS32_PAD_WIDTH) + 2 * N_FLASH;

    logic                           vdp_clk;
    logic                           vdp_reset;
    logic                           bus_valid;
    logic [`ICS32_ADDR_WIDTH-1:0]   bus_address;
    logic [`ICS32_DATA_WIDTH/8-1:0] bus_wstrb;
    logic [`ICS32_DATA_WIDTH-1:0]   bus_write_data;
    logic                           btn_1;
    logic                           btn_2;
    logic                           btn_3;
    logic [3:0]                     flash_out;
    logic                           bus_ready;
    logic [`ICS32_DATA_WIDTH-1:0]   bus_read_data;
    logic                           led_r;
    logic                           led_b;
    logic                           flash_clk;
    logic                           flash_csn;
    logic [3:0]                     flash_in;
    logic [3:0]                     flash_in_en;

    // Register model
    logic [1:0]         m_status;
    logic signed [15:0] m_a;
    logic signed [15:0] m_b;
    logic [1:0]         m_pad_ctrl;
    logic [15:0]        m_pad;
    logic [15:0]        m_flash;

    integer      seed = 48148;
    int          errors = 0;
    int          checks = 0;
    string       name_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] act_q[$];
    event        check_ev;

    ics32_periph dut (.*);

    initial begin
        vdp_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) vdp_clk = ~vdp_clk;
        end
    end

    // Expected read data for a region, from the model state
    function automatic logic [31:0] ref_read(input logic [3:0] region);
        logic signed [31:0] prod;
        prod = m_a * m_b;
        case (region)
            `ICS32_REGION_DSP:   return prod;
            `ICS32_REGION_PAD:   return {31'b0, m_pad[0]};
            `ICS32_REGION_FLASH: return {28'b0, flash_out};
            default:             return 32'b0;
        endcase
    endfunction

    // Pins as {clk, csn, oe, data}
    function automatic logic [9:0] ref_pins();
        if (m_flash[15]) begin
            return {m_flash[8], m_flash[9], m_flash[7:4], m_flash[3:0]};
        end
        return {1'b0, 1'b1, 8'h00};
    endfunction

    task automatic model_write(input logic [3:0] region, input logic index,
                               input logic [31:0] data);
        case (region)
            `ICS32_REGION_STATUS: m_status = data[1:0];
            `ICS32_REGION_DSP: begin
                if (index) begin
                    m_b = data[15:0];
                end else begin
                    m_a = data[15:0];
                end
            end
            `ICS32_REGION_PAD: begin
                // A held latch reloads after the shift
                if (data[1] && !m_pad_ctrl[1]) begin
                    m_pad = m_pad >> 1;
                end
                if (data[0]) begin
                    m_pad = {8'b0, btn_1, btn_3, 5'b0, btn_2};
                end
                m_pad_ctrl = data[1:0];
            end
            `ICS32_REGION_FLASH: m_flash = data[15:0];
            default: ;
        endcase
    endtask

    task automatic post_check(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        name_q.push_back(name);
        exp_q.push_back(expected);
        act_q.push_back(actual);
        ->check_ev;
    endtask

    task automatic bus_access(input string name, input logic [3:0] region, input logic index,
                              input logic write, input logic [31:0] data);
        int          cycles;
        logic [31:0] expected;
        cycles         = 0;
        expected       = ref_read(region);
        bus_valid      = 1'b1;
        bus_address    = {4'h0, region, 13'h0, index, 2'b00};
        bus_wstrb      = write ? 4'hf : 4'h0;
        bus_write_data = data;
        do begin
            @(posedge vdp_clk);
            #DRIVE_DELAY;
            cycles++;
        end while (!bus_ready && cycles < 8);
        if (!bus_ready) begin
            errors++;
            $display("%s: bus_ready never came within %0d cycles", name, cycles);
        end
        post_check({name, " ready"}, 2, cycles);
        if (write) begin
            model_write(region, index, data);
        end else begin
            post_check(name, expected, bus_read_data);
        end
        // Ready is seen on the next edge, then valid drops
        @(posedge vdp_clk);
        #DRIVE_DELAY;
        bus_valid = 1'b0;
        bus_wstrb = 4'h0;
        @(posedge vdp_clk);
        #DRIVE_DELAY;
    endtask

    // Compare process
    initial begin
        string       name;
        logic [31:0] expected;
        logic [31:0] actual;
        forever begin
            @(check_ev);
            while (act_q.size() > 0) begin
                name     = name_q.pop_front();
                expected = exp_q.pop_front();
                actual   = act_q.pop_front();
                checks++;
                if (actual !== expected) begin
                    errors++;
                    $display("error %s: expected %0h, actual %0h", name, expected, actual);
                end
            end
        end
    end

    initial begin
        #(NUM_TESTS * 20 * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("tests failed");
        $finish;
    end

    initial begin
        logic [31:0] data;
        vdp_reset      = 1'b1;
        bus_valid      = 1'b0;
        bus_address    = '0;
        bus_wstrb      = '0;
        bus_write_data = '0;
        btn_1          = 1'b0;
        btn_2          = 1'b0;
        btn_3          = 1'b0;
        flash_out      = 4'h0;
        m_status       = 2'b01;
        m_a            = '0;
        m_b            = '0;
        m_pad_ctrl     = 2'b00;
        m_pad          = '0;
        m_flash        = '0;
        repeat (5) @(posedge vdp_clk);
        #DRIVE_DELAY;
        vdp_reset = 1'b0;
        post_check("reset leds", m_status, {led_b, led_r});
        post_check("reset flash pins", ref_pins(), {flash_clk, flash_csn, flash_in_en, flash_in});

        for (int i = 0; i < N_STATUS; i++) begin
            data = $random(seed);
            bus_access("status write", `ICS32_REGION_STATUS, 1'b0, 1'b1, data);
            post_check("status leds", m_status, {led_b, led_r});
            bus_access("status read", `ICS32_REGION_STATUS, 1'b0, 1'b0, 32'h0);
        end

        for (int r = 4; r < 16; r++) begin
            bus_access("unmapped write", 4'(r), 1'b0, 1'b1, $random(seed));
            bus_access("unmapped read", 4'(r), 1'b1, 1'b0, 32'h0);
        end

        for (int i = 0; i < N_MULT; i++) begin
            bus_access("dsp operand a", `ICS32_REGION_DSP, 1'b0, 1'b1, $random(seed));
            bus_access("dsp operand b", `ICS32_REGION_DSP, 1'b1, 1'b1, $random(seed));
            bus_access("dsp product", `ICS32_REGION_DSP, 1'b0, 1'b0, 32'h0);
        end

        // Buttons only change while the latch is released
        for (int i = 0; i < N_PAD; i++) begin
            {btn_1, btn_2, btn_3} = 3'($random(seed));
            bus_access("pad latch", `ICS32_REGION_PAD, 1'b0, 1'b1, 32'h1);
            bus_access("pad release", `ICS32_REGION_PAD, 1'b0, 1'b1, 32'h0);
            for (int b = 0; b < `ICS32_PAD_WIDTH; b++) begin
                bus_access("pad bit", `ICS32_REGION_PAD, 1'b0, 1'b0, 32'h0);
                bus_access("pad clock high", `ICS32_REGION_PAD, 1'b0, 1'b1, 32'h2);
                bus_access("pad clock low", `ICS32_REGION_PAD, 1'b0, 1'b1, 32'h0);
            end
        end

        for (int i = 0; i < N_FLASH; i++) begin
            data     = $random(seed);
            data[15] = (i % 3 != 2);
            bus_access("flash control", `ICS32_REGION_FLASH, 1'b0, 1'b1, data);
            post_check("flash pins", ref_pins(), {flash_clk, flash_csn, flash_in_en, flash_in});
            flash_out = 4'($random(seed));
            bus_access("flash read", `ICS32_REGION_FLASH, 1'b0, 1'b0, 32'h0);
        end

        @(posedge vdp_clk);
        // Failed protocol assertions count as errors too
        errors += dut.protocol_check.failures;
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* src/address_decoder.sv */
// Address decoder
// Accepts one valid/ready request at a time, decodes its region and
// issues a single-cycle request strobe to the peripherals

`include "ics32_periph_cfg.svh"

module address_decoder (
    input  logic                          vdp_clk,
    input  logic                          vdp_reset,
    input  logic                          bus_valid,
    input  logic [`ICS32_ADDR_WIDTH-1:0]  bus_address,
    input  logic [`ICS32_DATA_WIDTH/8-1:0] bus_wstrb,
    input  logic [`ICS32_DATA_WIDTH-1:0]  bus_write_data,
    input  logic                          bus_ready,
    periph_bus_if.decoder                 bus
);

    logic       busy;
    logic       accept;
    logic [3:0] region;

    // Valid is held until ready, so ignore it while a request is in flight
    assign accept = bus_valid && !busy;
    assign region = bus_address[`ICS32_REGION_LSB +: 4];

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            busy    <= 1'b0;
            bus.req <= 1'b0;
        end else begin
            bus.req <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (bus_ready) begin
                busy <= 1'b0;
            end
        end
    end

    // Request payload is only meaningful alongside req
    always_ff @(posedge vdp_clk) begin
        if (accept) begin
            bus.sel.status <= (region == `ICS32_REGION_STATUS);
            bus.sel.dsp    <= (region == `ICS32_REGION_DSP);
            bus.sel.pad    <= (region == `ICS32_REGION_PAD);
            bus.sel.flash  <= (region == `ICS32_REGION_FLASH);
            bus.write      <= |bus_wstrb;
            bus.reg_index  <= bus_address[2];
            bus.write_data <= bus_write_data;
        end
    end

endmodule

/* src/bus_arbiter.sv */
// Bus arbiter
// Owns the LED status register, picks read data from the selected
// peripheral and returns a one-cycle ready

`include "ics32_periph_cfg.svh"

module bus_arbiter (
    input  logic                        vdp_clk,
    input  logic                        vdp_reset,
    periph_bus_if.arbiter               bus,
    input  ics32_periph_pkg::bus_word_t dsp_read_data,
    input  ics32_periph_pkg::bus_word_t pad_read_data,
    input  ics32_periph_pkg::bus_word_t flash_read_data,
    output logic                        bus_ready,
    output ics32_periph_pkg::bus_word_t bus_read_data,
    output logic                        led_r,
    output logic                        led_b
);

    logic [1:0]                  status;
    ics32_periph_pkg::bus_word_t read_mux;

    assign led_r = status[0];
    assign led_b = status[1];

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= `ICS32_STATUS_RESET;
        end else if (bus.req && bus.write && bus.sel.status) begin
            status <= bus.write_data[1:0];
        end
    end

    // Status and unmapped regions read as zero, as do writes
    always_comb begin
        read_mux = '0;
        if (!bus.write) begin
            if (bus.sel.dsp) begin
                read_mux = dsp_read_data;
            end else if (bus.sel.pad) begin
                read_mux = pad_read_data;
            end else if (bus.sel.flash) begin
                read_mux = flash_read_data;
            end
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            bus_ready <= 1'b0;
        end else begin
            bus_ready <= bus.req;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (bus.req) begin
            bus_read_data <= read_mux;
        end
    end

endmodule

/* src/dsp_multiplier.sv */
// Signed multiplier
// Two 16-bit operand registers feeding a registered 32-bit product

`include "ics32_periph_cfg.svh"

module dsp_multiplier (
    input  logic                        vdp_clk,
    periph_bus_if.responder             bus,
    output ics32_periph_pkg::bus_word_t dsp_read_data
);

    logic signed [`ICS32_MULT_WIDTH-1:0] mult_a;
    logic signed [`ICS32_MULT_WIDTH-1:0] mult_b;
    logic                                write_en;

    assign write_en = bus.req && bus.write && bus.sel.dsp;

    // Register index selects the operand
    always_ff @(posedge vdp_clk) begin
        if (write_en && !bus.reg_index) begin
            mult_a <= bus.write_data[`ICS32_MULT_WIDTH-1:0];
        end
        if (write_en && bus.reg_index) begin
            mult_b <= bus.write_data[`ICS32_MULT_WIDTH-1:0];
        end
    end

    // Product is recomputed every cycle
    always_ff @(posedge vdp_clk) begin
        dsp_read_data <= mult_a * mult_b;
    end

endmodule

/* src/flash_ctrl.sv */
// Flash control
// Software bit-bangs the SPI flash pins through one control register;
// the pins stay idle unless software control is active

module flash_ctrl (
    input  logic                          vdp_clk,
    input  logic                          vdp_reset,
    periph_bus_if.responder               bus,
    input  logic [3:0]                    flash_out,
    output ics32_periph_pkg::flash_pins_t flash_pins,
    output ics32_periph_pkg::bus_word_t   flash_read_data
);

    // Clock low, deselected, nothing driven
    localparam ics32_periph_pkg::flash_pins_t IDLE_PINS = '{
        clk:      1'b0,
        csn:      1'b1,
        data_out: 4'h0,
        data_oe:  4'h0
    };

    ics32_periph_pkg::flash_pins_t sw_pins;
    logic                          active;
    logic                          write_en;

    assign write_en = bus.req && bus.write && bus.sel.flash;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            active <= 1'b0;
        end else if (write_en) begin
            active <= bus.write_data[15];
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (write_en) begin
            sw_pins.data_out <= bus.write_data[3:0];
            sw_pins.data_oe  <= bus.write_data[7:4];
            sw_pins.clk      <= bus.write_data[8];
            sw_pins.csn      <= bus.write_data[9];
        end
    end

    // Pins belong to software only while active
    assign flash_pins = active ? sw_pins : IDLE_PINS;

    // flash_out is expected to come from an IO register
    assign flash_read_data = ics32_periph_pkg::bus_word_t'(flash_out);

endmodule

/* src/gamepad_reader.sv */
// Gamepad reader
// Latch/clock control register loading the board buttons into a shift
// register, read one bit at a time

`include "ics32_periph_cfg.svh"

module gamepad_reader (
    input  logic                        vdp_clk,
    input  logic                        vdp_reset,
    input  logic                        btn_1,
    input  logic                        btn_2,
    input  logic                        btn_3,
    periph_bus_if.responder             bus,
    output ics32_periph_pkg::bus_word_t pad_read_data
);

    logic [1:0]                  pad_ctrl;
    logic                        pad_clk_r;
    logic                        pad_clk_rise;
    logic [`ICS32_PAD_WIDTH-1:0] pad_state;
    logic [`ICS32_PAD_WIDTH-1:0] latch_value;

    // Bit 0 is latch, bit 1 is pad clock
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_ctrl  <= 2'b00;
            pad_clk_r <= 1'b0;
        end else begin
            if (bus.req && bus.write && bus.sel.pad) begin
                pad_ctrl <= bus.write_data[1:0];
            end
            pad_clk_r <= pad_ctrl[1];
        end
    end

    assign pad_clk_rise = pad_ctrl[1] && !pad_clk_r;

    // B, right and left buttons
    always_comb begin
        latch_value    = '0;
        latch_value[0] = btn_2;
        latch_value[6] = btn_3;
        latch_value[7] = btn_1;
    end

    // Shift wins over latch when both are present
    always_ff @(posedge vdp_clk) begin
        if (pad_clk_rise) begin
            pad_state <= {1'b0, pad_state[`ICS32_PAD_WIDTH-1:1]};
        end else if (pad_ctrl[0]) begin
            pad_state <= latch_value;
        end
    end

    assign pad_read_data = ics32_periph_pkg::bus_word_t'(pad_state[0]);

endmodule

/* src/ics32_periph.sv */
// Peripheral bus slave
// Top level joining the address decoder, status/arbiter, multiplier,
// gamepad reader and flash control

`include "ics32_periph_cfg.svh"

module ics32_periph (
    input  logic                           vdp_clk,
    input  logic                           vdp_reset,
    input  logic                           bus_valid,
    input  logic [`ICS32_ADDR_WIDTH-1:0]   bus_address,
    input  logic [`ICS32_DATA_WIDTH/8-1:0] bus_wstrb,
    input  logic [`ICS32_DATA_WIDTH-1:0]   bus_write_data,
    input  logic                           btn_1,
    input  logic                           btn_2,
    input  logic                           btn_3,
    input  logic [3:0]                     flash_out,
    output logic                           bus_ready,
    output logic [`ICS32_DATA_WIDTH-1:0]   bus_read_data,
    output logic                           led_r,
    output logic                           led_b,
    output logic                           flash_clk,
    output logic                           flash_csn,
    output logic [3:0]                     flash_in,
    output logic [3:0]                     flash_in_en
);

    ics32_periph_pkg::bus_word_t   dsp_read_data;
    ics32_periph_pkg::bus_word_t   pad_read_data;
    ics32_periph_pkg::bus_word_t   flash_read_data;
    ics32_periph_pkg::flash_pins_t flash_pins;

    periph_bus_if periph_bus ();

    address_decoder decoder (
        .vdp_clk        (vdp_clk),
        .vdp_reset      (vdp_reset),
        .bus_valid      (bus_valid),
        .bus_address    (bus_address),
        .bus_wstrb      (bus_wstrb),
        .bus_write_data (bus_write_data),
        .bus_ready      (bus_ready),
        .bus            (periph_bus.decoder)
    );

    bus_arbiter arbiter (
        .vdp_clk         (vdp_clk),
        .vdp_reset       (vdp_reset),
        .bus             (periph_bus.arbiter),
        .dsp_read_data   (dsp_read_data),
        .pad_read_data   (pad_read_data),
        .flash_read_data (flash_read_data),
        .bus_ready       (bus_ready),
        .bus_read_data   (bus_read_data),
        .led_r           (led_r),
        .led_b           (led_b)
    );

    dsp_multiplier dsp (
        .vdp_clk       (vdp_clk),
        .bus           (periph_bus.responder),
        .dsp_read_data (dsp_read_data)
    );

    gamepad_reader pad (
        .vdp_clk       (vdp_clk),
        .vdp_reset     (vdp_reset),
        .btn_1         (btn_1),
        .btn_2         (btn_2),
        .btn_3         (btn_3),
        .bus           (periph_bus.responder),
        .pad_read_data (pad_read_data)
    );

    flash_ctrl flash (
        .vdp_clk         (vdp_clk),
        .vdp_reset       (vdp_reset),
        .bus             (periph_bus.responder),
        .flash_out       (flash_out),
        .flash_pins      (flash_pins),
        .flash_read_data (flash_read_data)
    );

    assign flash_clk   = flash_pins.clk;
    assign flash_csn   = flash_pins.csn;
    assign flash_in    = flash_pins.data_out;
    assign flash_in_en = flash_pins.data_oe;

endmodule

/* src/ics32_periph_cfg.svh */
// Peripheral configuration
// Bus widths, region codes and reset values for the peripheral bus slave

`ifndef ICS32_PERIPH_CFG_SVH
`define ICS32_PERIPH_CFG_SVH

// Bus geometry
`define ICS32_ADDR_WIDTH 24
`define ICS32_DATA_WIDTH 32

// Region field is 4 bits starting here
`define ICS32_REGION_LSB 16

`define ICS32_REGION_STATUS 4'd0
`define ICS32_REGION_DSP    4'd1
`define ICS32_REGION_PAD    4'd2
`define ICS32_REGION_FLASH  4'd3

// Red LED on out of reset
`define ICS32_STATUS_RESET 2'b01

`define ICS32_PAD_WIDTH  16
`define ICS32_MULT_WIDTH 16

`endif

/* src/ics32_periph_pkg.sv */
// Peripheral package
// Shared types for the bus word, region selects and flash pins

`include "ics32_periph_cfg.svh"

package ics32_periph_pkg;

    typedef logic [`ICS32_DATA_WIDTH-1:0] bus_word_t;

    // One-hot region select
    typedef struct packed {
        logic status;
        logic dsp;
        logic pad;
        logic flash;
    } periph_sel_t;

    // SPI flash pin set driven towards the flash
    typedef struct packed {
        logic       clk;
        logic       csn;
        logic [3:0] data_out;
        logic [3:0] data_oe;
    } flash_pins_t;

endpackage

/* src/periph_bus_if.sv */
// Decoded peripheral request
// One registered request from the address decoder to the responders and arbiter

interface periph_bus_if;

    ics32_periph_pkg::periph_sel_t sel;
    logic                          write;
    logic                          reg_index;
    ics32_periph_pkg::bus_word_t   write_data;
    // High for one cycle per accepted request
    logic                          req;

    modport decoder (
        output sel, write, reg_index, write_data, req
    );

    modport responder (
        input sel, write, reg_index, write_data, req
    );

    modport arbiter (
        input sel, write, reg_index, write_data, req
    );

endinterface
